// ==== hdl/mem_qos_pkg.sv ====
// ----------------------------------------------------------
// Shared types and constants for the memory QoS port
// Import wherever request, response or QoS tags are handled
// ----------------------------------------------------------

package mem_qos_pkg;

    // ----------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // Transaction IDs per source
    localparam logic [ID_W-1:0] FETCH_ID = 4'd0;
    localparam logic [ID_W-1:0] DATA_ID  = 4'd1;

    // ----------------------------------------------------------
    // QoS levels and latency budgets
    // ----------------------------------------------------------
    localparam logic [2:0] QOS_LVL_MED      = 3'd1;
    localparam logic [2:0] QOS_LVL_MED_HIGH = 3'd2;
    localparam logic [2:0] QOS_LVL_HIGH     = 3'd3;
    localparam logic [2:0] QOS_LVL_CRIT     = 3'd4;

    // Budgets in cycles
    localparam logic [7:0] LAT_FETCH_NORM = 8'd32;
    localparam logic [7:0] LAT_FETCH_CRIT = 8'd8;
    localparam logic [7:0] LAT_LOAD_NORM  = 8'd24;
    localparam logic [7:0] LAT_STORE_NORM = 8'd48;
    localparam logic [7:0] LAT_DATA_CRIT  = 8'd8;

    // ----------------------------------------------------------
    // Payload types
    // ----------------------------------------------------------
    // 17-bit tag carried next to every request
    typedef struct packed {
        logic [2:0] level;
        logic       urgent;
        logic       is_data;
        logic [3:0] core_id;
        logic [7:0] max_latency;
    } qos_tag_t;

    // 73-bit memory request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] wdata;
        logic [ID_W-1:0]   id;
    } mem_req_t;

    // 37-bit memory response
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              error;
        logic [ID_W-1:0]   id;
    } mem_rsp_t;

    // Request plus its tag, 90 bits
    typedef struct packed {
        mem_req_t req;
        qos_tag_t tag;
    } mem_qreq_t;

endpackage

// ==== hdl/qos_class_gen.sv ====
// ----------------------------------------------------------
// QoS tag generation for fetch and data requests
// Purely combinational, both tags valid every cycle
// ----------------------------------------------------------
`timescale 1ns/100ps

module qos_class_gen import mem_qos_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic     exception_pending_i,
    input  logic     data_write_i,
    output qos_tag_t fetch_tag_o,
    output qos_tag_t data_tag_o
);

    // Fetch tag
    always_comb begin
        fetch_tag_o         = '0;
        fetch_tag_o.is_data = 1'b0;
        fetch_tag_o.core_id = 4'(CORE_ID);
        if (exception_pending_i) begin
            // Refetch of the handler must not wait
            fetch_tag_o.level       = QOS_LVL_CRIT;
            fetch_tag_o.urgent      = 1'b1;
            fetch_tag_o.max_latency = LAT_FETCH_CRIT;
        end else begin
            fetch_tag_o.level       = QOS_LVL_HIGH;
            fetch_tag_o.urgent      = 1'b0;
            fetch_tag_o.max_latency = LAT_FETCH_NORM;
        end
    end

    // Data tag, class from the pending request's write bit
    always_comb begin
        data_tag_o         = '0;
        data_tag_o.is_data = 1'b1;
        data_tag_o.core_id = 4'(CORE_ID);
        if (exception_pending_i) begin
            data_tag_o.level       = QOS_LVL_CRIT;
            data_tag_o.urgent      = 1'b1;
            data_tag_o.max_latency = LAT_DATA_CRIT;
        end else begin
            // Loads rank above stores, stores tolerate more latency
            data_tag_o.level       = data_write_i ? QOS_LVL_MED : QOS_LVL_MED_HIGH;
            data_tag_o.urgent      = 1'b0;
            data_tag_o.max_latency = data_write_i ? LAT_STORE_NORM : LAT_LOAD_NORM;
        end
    end

endmodule

// ==== hdl/mem_req_arbiter.sv ====
// ----------------------------------------------------------
// Fetch/data request arbiter with QoS priority
// Stamps ID and fixed fields, feeds the request slice
// ----------------------------------------------------------
`timescale 1ns/100ps

module mem_req_arbiter import mem_qos_pkg::*; (
    input  logic              qos_enable_i,
    input  qos_tag_t          core_qos_tag_i,
    // Fetch source
    input  logic              fetch_req_valid_i,
    input  logic [ADDR_W-1:0] fetch_addr_i,
    // Data source
    input  logic              data_req_valid_i,
    input  logic              data_write_i,
    input  logic [STRB_W-1:0] data_strb_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic [DATA_W-1:0] data_wdata_i,
    // Tags from the class generator
    input  qos_tag_t          fetch_tag_i,
    input  qos_tag_t          data_tag_i,
    // Downstream side
    input  logic              out_ready_i,
    output logic              fetch_req_ready_o,
    output logic              data_req_ready_o,
    output logic              out_valid_o,
    output mem_qreq_t         out_o
);

    logic fetch_win;

    // ----------------------------------------------------------
    // Winner selection
    // ----------------------------------------------------------
    always_comb begin
        fetch_win = fetch_req_valid_i;
        if (qos_enable_i && fetch_req_valid_i && data_req_valid_i) begin
            if (fetch_tag_i.level > data_tag_i.level) begin
                fetch_win = 1'b1;
            end else if (fetch_tag_i.level == data_tag_i.level) begin
                // Tie broken by urgency only
                fetch_win = fetch_tag_i.urgent && !data_tag_i.urgent;
            end else begin
                fetch_win = 1'b0;
            end
        end
    end

    // Only the winner sees ready
    assign fetch_req_ready_o = fetch_win && out_ready_i;
    assign data_req_ready_o  = !fetch_win && data_req_valid_i && out_ready_i;
    assign out_valid_o       = fetch_req_valid_i || data_req_valid_i;

    // ----------------------------------------------------------
    // Request build
    // ----------------------------------------------------------
    always_comb begin
        if (fetch_win) begin
            // Fetch is a full-word read
            out_o.req.addr  = fetch_addr_i;
            out_o.req.write = 1'b0;
            out_o.req.strb  = '1;
            out_o.req.wdata = '0;
            out_o.req.id    = FETCH_ID;
            out_o.tag       = fetch_tag_i;
        end else begin
            out_o.req.addr  = data_addr_i;
            out_o.req.write = data_write_i;
            out_o.req.strb  = data_strb_i;
            out_o.req.wdata = data_wdata_i;
            out_o.req.id    = DATA_ID;
            out_o.tag       = data_tag_i;
        end
        // Base core tag when QoS is off
        if (!qos_enable_i) begin
            out_o.tag = core_qos_tag_i;
        end
    end

endmodule

// ==== hdl/pipe_slice.sv ====
// ----------------------------------------------------------
// Two-entry valid/ready register slice, any payload type
// Registered output, full throughput, one cycle latency
// ----------------------------------------------------------
`timescale 1ns/100ps

module pipe_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    // Skid entry behind the output register
    logic     skid_valid_q;
    payload_t skid_data_q;

    // Ready drops only with both entries full
    assign in_ready_o = !skid_valid_q;

    // Valid flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_o  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_ready_i || !out_valid_o) begin
            // Output drains, refill from skid first
            out_valid_o  <= skid_valid_q || in_valid_i;
            skid_valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            // Output stalled, park the new item
            skid_valid_q <= 1'b1;
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (out_ready_i || !out_valid_o) begin
            out_data_o <= skid_valid_q ? skid_data_q : in_data_i;
        end else if (in_valid_i && in_ready_o) begin
            skid_data_q <= in_data_i;
        end
    end

endmodule

// ==== hdl/rsp_router.sv ====
// ----------------------------------------------------------
// Response router, steers by transaction ID
// FETCH_ID goes to the fetch port, all else to data
// ----------------------------------------------------------
`timescale 1ns/100ps

module rsp_router import mem_qos_pkg::*; (
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  mem_rsp_t in_rsp_i,
    // Fetch port
    output logic     fetch_rsp_valid_o,
    output mem_rsp_t fetch_rsp_o,
    input  logic     fetch_rsp_ready_i,
    // Data port
    output logic     data_rsp_valid_o,
    output mem_rsp_t data_rsp_o,
    input  logic     data_rsp_ready_i
);

    logic to_fetch;

    // ID decode
    assign to_fetch = (in_rsp_i.id == FETCH_ID);

    // Exactly one side sees valid
    assign fetch_rsp_valid_o = in_valid_i && to_fetch;
    assign data_rsp_valid_o  = in_valid_i && !to_fetch;

    // Unselected side gets zero payload
    assign fetch_rsp_o = to_fetch ? in_rsp_i : '0;
    assign data_rsp_o  = to_fetch ? '0 : in_rsp_i;

    // Back-pressure from the chosen port
    assign in_ready_o = to_fetch ? fetch_rsp_ready_i : data_rsp_ready_i;

endmodule

// ==== hdl/qos_violation_mon.sv ====
// ----------------------------------------------------------
// Counts stalled request cycles while QoS is enabled
// ----------------------------------------------------------
`timescale 1ns/100ps

module qos_violation_mon #(
    parameter int CNT_W = 16
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             qos_enable_i,
    input  logic             req_valid_i,
    input  logic             req_ready_i,
    output logic [CNT_W-1:0] violations_o
);

    logic stall;

    // Offered but not taken
    assign stall = qos_enable_i && req_valid_i && !req_ready_i;

    // Saturating count, holds at all ones
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            violations_o <= '0;
        end else if (stall && !(&violations_o)) begin
            violations_o <= violations_o + 1'b1;
        end
    end

endmodule

// ==== hdl/mem_qos_port.sv ====
// ----------------------------------------------------------
// Memory-side QoS port, merges fetch and data onto one bus
// Instances and wiring only, parameters passed down
// ----------------------------------------------------------
`timescale 1ns/100ps

module mem_qos_port import mem_qos_pkg::*; #(
    parameter int CORE_ID = 0,
    parameter int CNT_W   = 16
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // QoS control
    input  logic              qos_enable_i,
    input  qos_tag_t          core_qos_tag_i,
    input  logic              exception_pending_i,
    output logic [CNT_W-1:0]  qos_violations_o,
    // Fetch source
    input  logic              fetch_req_valid_i,
    output logic              fetch_req_ready_o,
    input  logic [ADDR_W-1:0] fetch_addr_i,
    output logic              fetch_rsp_valid_o,
    output mem_rsp_t          fetch_rsp_o,
    input  logic              fetch_rsp_ready_i,
    // Data source
    input  logic              data_req_valid_i,
    output logic              data_req_ready_o,
    input  logic              data_write_i,
    input  logic [STRB_W-1:0] data_strb_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic [DATA_W-1:0] data_wdata_i,
    output logic              data_rsp_valid_o,
    output mem_rsp_t          data_rsp_o,
    input  logic              data_rsp_ready_i,
    // Shared memory port
    output logic              mem_req_valid_o,
    output mem_req_t          mem_req_o,
    output qos_tag_t          mem_qos_o,
    input  logic              mem_req_ready_i,
    input  logic              mem_rsp_valid_i,
    input  mem_rsp_t          mem_rsp_i,
    output logic              mem_rsp_ready_o
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    qos_tag_t  fetch_tag;
    qos_tag_t  data_tag;
    logic      arb_valid;
    logic      arb_ready;
    mem_qreq_t arb_qreq;
    mem_qreq_t mem_qreq;
    logic      rsp_valid;
    logic      rsp_ready;
    mem_rsp_t  rsp;

    // Split the slice output onto the memory port
    assign mem_req_o = mem_qreq.req;
    assign mem_qos_o = mem_qreq.tag;

    qos_class_gen #(
        .CORE_ID (CORE_ID)
    ) u_class_gen (
        .exception_pending_i (exception_pending_i),
        .data_write_i        (data_write_i),
        .fetch_tag_o         (fetch_tag),
        .data_tag_o          (data_tag)
    );

    mem_req_arbiter u_arbiter (
        .qos_enable_i      (qos_enable_i),
        .core_qos_tag_i    (core_qos_tag_i),
        .fetch_req_valid_i (fetch_req_valid_i),
        .fetch_addr_i      (fetch_addr_i),
        .data_req_valid_i  (data_req_valid_i),
        .data_write_i      (data_write_i),
        .data_strb_i       (data_strb_i),
        .data_addr_i       (data_addr_i),
        .data_wdata_i      (data_wdata_i),
        .fetch_tag_i       (fetch_tag),
        .data_tag_i        (data_tag),
        .out_ready_i       (arb_ready),
        .fetch_req_ready_o (fetch_req_ready_o),
        .data_req_ready_o  (data_req_ready_o),
        .out_valid_o       (arb_valid),
        .out_o             (arb_qreq)
    );

    // Request slice, tag travels with the request
    pipe_slice #(
        .payload_t (mem_qreq_t)
    ) u_req_slice (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (arb_valid),
        .in_ready_o  (arb_ready),
        .in_data_i   (arb_qreq),
        .out_valid_o (mem_req_valid_o),
        .out_ready_i (mem_req_ready_i),
        .out_data_o  (mem_qreq)
    );

    // Response slice
    pipe_slice #(
        .payload_t (mem_rsp_t)
    ) u_rsp_slice (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (mem_rsp_valid_i),
        .in_ready_o  (mem_rsp_ready_o),
        .in_data_i   (mem_rsp_i),
        .out_valid_o (rsp_valid),
        .out_ready_i (rsp_ready),
        .out_data_o  (rsp)
    );

    rsp_router u_router (
        .in_valid_i        (rsp_valid),
        .in_ready_o        (rsp_ready),
        .in_rsp_i          (rsp),
        .fetch_rsp_valid_o (fetch_rsp_valid_o),
        .fetch_rsp_o       (fetch_rsp_o),
        .fetch_rsp_ready_i (fetch_rsp_ready_i),
        .data_rsp_valid_o  (data_rsp_valid_o),
        .data_rsp_o        (data_rsp_o),
        .data_rsp_ready_i  (data_rsp_ready_i)
    );

    // Watches the memory side of the request slice
    qos_violation_mon #(
        .CNT_W (CNT_W)
    ) u_violation_mon (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .qos_enable_i (qos_enable_i),
        .req_valid_i  (mem_req_valid_o),
        .req_ready_i  (mem_req_ready_i),
        .violations_o (qos_violations_o)
    );

endmodule

// ==== verification/mem_qos_port_chk.sv ====
// ----------------------------------------------------------
// Assertion checker bound into the memory QoS port
// ----------------------------------------------------------
`timescale 1ns/100ps

module mem_qos_port_chk import mem_qos_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        qos_enable_i,
    input logic        exception_pending_i,
    input logic        fetch_req_valid_i,
    input logic        data_req_valid_i,
    input logic        mem_req_valid_o,
    input logic        mem_req_ready_i,
    input mem_req_t    mem_req_o,
    input qos_tag_t    mem_qos_o,
    input logic        fetch_req_ready_o,
    input logic        data_req_ready_o,
    input logic        fetch_rsp_valid_o,
    input mem_rsp_t    fetch_rsp_o,
    input logic        data_rsp_valid_o,
    input mem_rsp_t    data_rsp_o,
    input logic [15:0] qos_violations_o
);

    // Stalled request holds still
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=>
        mem_req_valid_o && $stable(mem_req_o) && $stable(mem_qos_o))
        else $error("request changed under back-pressure");

    // Fetch requests carry the fixed fields
    a_fetch_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_o.id == FETCH_ID |->
        !mem_req_o.write && mem_req_o.strb == '1 && mem_req_o.wdata == '0)
        else $error("fetch request with wrong fixed fields");

    // Data only wins contention on a pending exception with QoS on
    a_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_req_valid_i && data_req_valid_i |->
        ((qos_enable_i && exception_pending_i) ? !fetch_req_ready_o : !data_req_ready_o))
        else $error("grant against the QoS priority rule");

    // Routing by ID
    a_route: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(fetch_rsp_valid_o && data_rsp_valid_o) &&
        (!fetch_rsp_valid_o || fetch_rsp_o.id == FETCH_ID) &&
        (!data_rsp_valid_o || data_rsp_o.id != FETCH_ID))
        else $error("response routed to the wrong port");

    // Each stalled cycle adds one
    a_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
        qos_enable_i && mem_req_valid_o && !mem_req_ready_i && !(&qos_violations_o) |=>
        qos_violations_o == $past(qos_violations_o) + 16'd1)
        else $error("violation count did not step");

endmodule

bind mem_qos_port mem_qos_port_chk u_chk (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .qos_enable_i        (qos_enable_i),
    .exception_pending_i (exception_pending_i),
    .fetch_req_valid_i   (fetch_req_valid_i),
    .data_req_valid_i    (data_req_valid_i),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_req_ready_i     (mem_req_ready_i),
    .mem_req_o           (mem_req_o),
    .mem_qos_o           (mem_qos_o),
    .fetch_req_ready_o   (fetch_req_ready_o),
    .data_req_ready_o    (data_req_ready_o),
    .fetch_rsp_valid_o   (fetch_rsp_valid_o),
    .fetch_rsp_o         (fetch_rsp_o),
    .data_rsp_valid_o    (data_rsp_valid_o),
    .data_rsp_o          (data_rsp_o),
    .qos_violations_o    (qos_violations_o)
);

// ==== verification/tb_mem_qos_port.sv ====
// ----------------------------------------------------------
// Testbench for the memory QoS port, directed sequences
// Request scoreboard plus bound assertion checker
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_mem_qos_port import mem_qos_pkg::*;;

    localparam int TIMEOUT = 50;
    localparam int N_STALL = 5;

    logic clk_i, rst_ni, qos_enable_i, exception_pending_i;
    qos_tag_t core_qos_tag_i, mem_qos_o;
    logic [15:0] qos_violations_o;
    logic fetch_req_valid_i, fetch_req_ready_o, fetch_rsp_valid_o, fetch_rsp_ready_i;
    logic [ADDR_W-1:0] fetch_addr_i, data_addr_i;
    logic data_req_valid_i, data_req_ready_o, data_write_i, data_rsp_valid_o, data_rsp_ready_i;
    logic [STRB_W-1:0] data_strb_i;
    logic [DATA_W-1:0] data_wdata_i;
    mem_rsp_t fetch_rsp_o, data_rsp_o, mem_rsp_i;
    logic mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i, mem_rsp_ready_o;
    mem_req_t mem_req_o;

    int seed = 32'h480e;
    int err_cnt = 0;
    int lost_cnt;
    logic [15:0] cnt0;
    mem_req_t exp_req_q[$];
    qos_tag_t exp_tag_q[$];

    mem_qos_port #(.CORE_ID(5), .CNT_W(16)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Tag expected from the class rules
    function automatic qos_tag_t rule_tag(logic is_data, logic write, logic exc);
        qos_tag_t t;
        t = '0;
        t.is_data = is_data;
        t.core_id = 4'd5;
        t.urgent = exc;
        if (exc) begin
            t.level = QOS_LVL_CRIT;
            t.max_latency = is_data ? LAT_DATA_CRIT : LAT_FETCH_CRIT;
        end else if (!is_data) begin
            t.level = QOS_LVL_HIGH;
            t.max_latency = LAT_FETCH_NORM;
        end else begin
            t.level = write ? QOS_LVL_MED : QOS_LVL_MED_HIGH;
            t.max_latency = write ? LAT_STORE_NORM : LAT_LOAD_NORM;
        end
        return t;
    endfunction

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("Error %s got %0h expected %0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic timed_out(string what);
        $display("Timeout while waiting for %s", what);
        $display("sim failed");
        $finish;
    endtask

    // Expected entry, order fixed by the test
    task automatic expect_req(logic is_data, logic [31:0] addr, logic wr, logic [3:0] strb,
                              logic [31:0] wdata, qos_tag_t tag);
        exp_req_q.push_back({addr, wr, strb, wdata, is_data ? DATA_ID : FETCH_ID});
        exp_tag_q.push_back(tag);
    endtask

    task automatic push_fetch(logic [31:0] addr);
        int t;
        t = 0;
        fetch_req_valid_i = 1'b1;
        fetch_addr_i = addr;
        @(negedge clk_i);
        while (!fetch_req_ready_o) begin
            if (++t > TIMEOUT) timed_out("fetch_req_ready_o");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1 fetch_req_valid_i = 1'b0;
    endtask

    task automatic push_data(logic wr, logic [31:0] addr, logic [31:0] wdata);
        int t;
        t = 0;
        data_req_valid_i = 1'b1;
        data_write_i = wr;
        data_addr_i = addr;
        data_wdata_i = wdata;
        data_strb_i = 4'hf;
        @(negedge clk_i);
        while (!data_req_ready_o) begin
            if (++t > TIMEOUT) timed_out("data_req_ready_o");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1 data_req_valid_i = 1'b0;
    endtask

    // Response in, then checked at its port a cycle later
    task automatic send_rsp(mem_rsp_t r, logic check);
        int t;
        t = 0;
        mem_rsp_valid_i = 1'b1;
        mem_rsp_i = r;
        @(negedge clk_i);
        while (!mem_rsp_ready_o) begin
            if (++t > TIMEOUT) timed_out("mem_rsp_ready_o");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1 mem_rsp_valid_i = 1'b0;
        if (check && r.id == FETCH_ID) begin
            check_val("fetch_rsp_valid_o", fetch_rsp_valid_o, 1'b1);
            check_val("fetch_rsp_o", fetch_rsp_o, r);
        end else if (check) begin
            check_val("data_rsp_valid_o", data_rsp_valid_o, 1'b1);
            check_val("data_rsp_o", data_rsp_o, r);
        end
    endtask

    task automatic drain;
        int t;
        t = 0;
        while (exp_req_q.size() != 0) begin
            if (++t > TIMEOUT) timed_out("requests to drain");
            @(posedge clk_i);
            #1;
        end
    endtask

    // Scoreboard on the memory port
    always @(negedge clk_i) begin
        if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            if (exp_req_q.size() == 0) begin
                $display("Unexpected request at the memory port");
                err_cnt++;
            end else begin
                check_val("mem_req_o", mem_req_o, exp_req_q.pop_front());
                check_val("mem_qos_o", mem_qos_o, exp_tag_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] a0, a1, a2, d0;
        {rst_ni, qos_enable_i, exception_pending_i, fetch_req_valid_i} = '0;
        {data_req_valid_i, data_write_i, mem_rsp_valid_i} = '0;
        {fetch_addr_i, data_addr_i, data_wdata_i, data_strb_i, mem_rsp_i} = '0;
        core_qos_tag_i = '0;
        {fetch_rsp_ready_i, data_rsp_ready_i, mem_req_ready_i} = 3'b111;
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        qos_enable_i = 1'b1;
        @(negedge clk_i);
        check_val("mem_req_valid_o", mem_req_valid_o, 1'b0);
        check_val("fetch_rsp_valid_o", fetch_rsp_valid_o, 1'b0);
        check_val("data_rsp_valid_o", data_rsp_valid_o, 1'b0);
        check_val("qos_violations_o", qos_violations_o, 16'h0);
        check_val("mem_rsp_ready_o", mem_rsp_ready_o, 1'b1);
        @(posedge clk_i);
        #1;

        // Lone fetch, then lone store
        a0 = $random(seed);
        a1 = $random(seed);
        d0 = $random(seed);
        expect_req(1'b0, a0, 1'b0, 4'hf, '0, rule_tag(1'b0, 1'b0, 1'b0));
        push_fetch(a0);
        check_val("mem_req_valid_o", mem_req_valid_o, 1'b1);
        expect_req(1'b1, a1, 1'b1, 4'hf, d0, rule_tag(1'b1, 1'b1, 1'b0));
        push_data(1'b1, a1, d0);
        check_val("mem_req_valid_o", mem_req_valid_o, 1'b1);
        drain();

        // Contention without and with a pending exception
        for (int exc = 0; exc < 2; exc++) begin
            exception_pending_i = exc[0];
            a0 = $random(seed);
            a1 = $random(seed);
            if (exc == 0) expect_req(1'b0, a0, 1'b0, 4'hf, '0, rule_tag(1'b0, 1'b0, 1'b0));
            expect_req(1'b1, a1, 1'b0, 4'hf, d0, rule_tag(1'b1, 1'b0, exc[0]));
            if (exc == 1) expect_req(1'b0, a0, 1'b0, 4'hf, '0, rule_tag(1'b0, 1'b0, 1'b1));
            fork
                push_fetch(a0);
                push_data(1'b0, a1, d0);
            join
            drain();
        end

        // QoS off, fetch wins and the core tag passes through
        qos_enable_i = 1'b0;
        core_qos_tag_i = 17'($random(seed));
        expect_req(1'b0, a0, 1'b0, 4'hf, '0, core_qos_tag_i);
        expect_req(1'b1, a1, 1'b0, 4'hf, d0, core_qos_tag_i);
        cnt0 = qos_violations_o;
        mem_req_ready_i = 1'b0;
        fork
            push_fetch(a0);
            push_data(1'b0, a1, d0);
        join
        repeat (3) @(posedge clk_i);
        #1 mem_req_ready_i = 1'b1;
        drain();
        check_val("qos_violations_o", qos_violations_o, cnt0);
        exception_pending_i = 1'b0;
        qos_enable_i = 1'b1;

        // Memory stall for N cycles, three fetches queued behind it
        a0 = $random(seed);
        a1 = $random(seed);
        a2 = $random(seed);
        expect_req(1'b0, a0, 1'b0, 4'hf, '0, rule_tag(1'b0, 1'b0, 1'b0));
        expect_req(1'b0, a1, 1'b0, 4'hf, '0, rule_tag(1'b0, 1'b0, 1'b0));
        expect_req(1'b0, a2, 1'b0, 4'hf, '0, rule_tag(1'b0, 1'b0, 1'b0));
        mem_req_ready_i = 1'b0;
        fork
            begin
                push_fetch(a0);
                push_fetch(a1);
                push_fetch(a2);
            end
            begin
                int t;
                t = 0;
                @(negedge clk_i);
                while (!mem_req_valid_o) begin
                    if (++t > TIMEOUT) timed_out("mem_req_valid_o");
                    @(negedge clk_i);
                end
                cnt0 = qos_violations_o;
                repeat (N_STALL) @(posedge clk_i);
                @(negedge clk_i);
                check_val("fetch_req_ready_o", fetch_req_ready_o, 1'b0);
                check_val("qos_violations_o", qos_violations_o, cnt0 + N_STALL);
                @(posedge clk_i);
                #1 mem_req_ready_i = 1'b1;
            end
        join
        drain();
        check_val("qos_violations_o", qos_violations_o, cnt0 + N_STALL + 1);

        // Routing by ID, then back-pressure from the data port
        send_rsp({32'($random(seed)), 1'b0, FETCH_ID}, 1'b1);
        send_rsp({32'($random(seed)), 1'b1, DATA_ID}, 1'b1);
        send_rsp({32'($random(seed)), 1'b0, 4'd9}, 1'b1);
        @(posedge clk_i);
        #1 data_rsp_ready_i = 1'b0;
        send_rsp({32'($random(seed)), 1'b0, DATA_ID}, 1'b0);
        send_rsp({32'($random(seed)), 1'b0, DATA_ID}, 1'b0);
        check_val("mem_rsp_ready_o", mem_rsp_ready_o, 1'b0);
        data_rsp_ready_i = 1'b1;
        repeat (3) @(posedge clk_i);

        lost_cnt = exp_req_q.size();
        $display("Closing: %0d value errors, %0d requests missing", err_cnt, lost_cnt);
        if (err_cnt == 0 && lost_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== mem_qos_port.f ====
hdl/mem_qos_pkg.sv
hdl/qos_class_gen.sv
hdl/mem_req_arbiter.sv
hdl/pipe_slice.sv
hdl/rsp_router.sv
hdl/qos_violation_mon.sv
hdl/mem_qos_port.sv
verification/mem_qos_port_chk.sv
verification/tb_mem_qos_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory QoS port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_qos_port -f mem_qos_port.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
